//--- hdl/mem_cfg_pkg.sv
package mem_cfg_pkg;

    // Pixel and patch geometry
    localparam int DATA_WIDTH  = 11;
    localparam int PATCH_SIZE  = 5;
    localparam int PATCH_WIDTH = DATA_WIDTH * PATCH_SIZE;  // 55 bits of a 64-bit word

    // SRAM geometry
    localparam int ADDR_WIDTH = 9;
    localparam int DEPTH      = 512;
    localparam int WORD_WIDTH = 64;
    localparam int MASK_WIDTH = WORD_WIDTH / 8;  // One enable per byte lane

endpackage

//--- hdl/wb_bus_pkg.sv
package wb_bus_pkg;

    // Bus address of SRAM word 0
    localparam logic [31:0] WB_ADDRESS_OFFSET = 32'd557;

    // Five differences of at most 2047 each fit in 14 bits
    localparam int SCORE_WIDTH = 14;

    // Byte-lane write command
    typedef struct packed {
        logic [17:0] rsvd_hi;
        logic [2:0]  lane;     // Target byte lane of the word
        logic [2:0]  rsvd_lo;
        logic [7:0]  data;
    } wb_wr_view_t;

    // Half-patch read command
    typedef struct packed {
        logic [19:0] rsvd_hi;
        logic        half;     // 0 returns bits 31..0, 1 returns the upper 23 bits
        logic [10:0] rsvd_lo;
    } wb_rd_view_t;

    // Same data word, decoded by bus direction
    typedef union packed {
        wb_wr_view_t wr;
        wb_rd_view_t rd;
    } wb_cmd_u;

endpackage

//--- hdl/sram_1kbyte_1rw1r.sv
`timescale 1ns/1ps

// Behavioral stand-in for the dual-port macro
// Port 0 reads or writes, port 1 only reads
module sram_1kbyte_1rw1r
    import mem_cfg_pkg::*;
(
    // Port 0
    input  logic                  clk0_i,
    input  logic                  csb0_i,
    input  logic                  web0_i,
    input  logic [MASK_WIDTH-1:0] wmask_i,
    input  logic [ADDR_WIDTH-1:0] addr0_i,
    input  logic [WORD_WIDTH-1:0] din0_i,
    output logic [WORD_WIDTH-1:0] dout0_o,

    // Port 1
    input  logic                  clk1_i,
    input  logic                  csb1_i,
    input  logic [ADDR_WIDTH-1:0] addr1_i,
    output logic [WORD_WIDTH-1:0] dout1_o
);

    logic [WORD_WIDTH-1:0] mem [DEPTH];

    // Port 0 does masked byte writes or a registered read
    always_ff @(posedge clk0_i) begin
        if (!csb0_i) begin
            if (!web0_i) begin
                for (int lane = 0; lane < MASK_WIDTH; lane++) begin
                    if (wmask_i[lane]) begin
                        mem[addr0_i][lane*8 +: 8] <= din0_i[lane*8 +: 8];
                    end
                end
            end else begin
                dout0_o <= mem[addr0_i];  // Holds until the next read
            end
        end
    end

    // Port 1 sees the old word when port 0 writes the same address
    always_ff @(posedge clk1_i) begin
        if (!csb1_i) begin
            dout1_o <= mem[addr1_i];
        end
    end

endmodule

//--- hdl/query_patch_mem.sv
`timescale 1ns/1ps

module query_patch_mem
    import mem_cfg_pkg::*;
    import wb_bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   wb_mode_i,

    // Direct access on port 0
    input  logic                   csb0_i,
    input  logic                   web0_i,
    input  logic [ADDR_WIDTH-1:0]  addr0_i,
    input  logic [PATCH_WIDTH-1:0] wpatch0_i,
    output logic [PATCH_WIDTH-1:0] rpatch0_o,

    // Read-only port 1
    input  logic                   csb1_i,
    input  logic [ADDR_WIDTH-1:0]  addr1_i,
    output logic [PATCH_WIDTH-1:0] rpatch1_o,

    // Wishbone slave
    input  logic                   wbs_stb_i,
    input  logic                   wbs_cyc_i,
    input  logic                   wbs_we_i,
    input  logic [31:0]            wbs_dat_i,
    input  logic [31:0]            wbs_adr_i,
    output logic                   wbs_ack_o,
    output logic [31:0]            wbs_dat_o
);

    wb_cmd_u               wb_cmd;
    logic [31:0]           wb_addr;
    logic                  wb_req;
    logic [MASK_WIDTH-1:0] wb_mask;
    logic [WORD_WIDTH-1:0] wb_wdata;

    logic                  pending_q;
    logic                  rd_wait_q;
    logic                  ack_q;
    logic                  half_q;

    logic                  sram_csb0;
    logic                  sram_web0;
    logic [ADDR_WIDTH-1:0] sram_addr0;
    logic [MASK_WIDTH-1:0] sram_wmask;
    logic [WORD_WIDTH-1:0] sram_din0;
    logic [WORD_WIDTH-1:0] sram_dout0;
    logic [WORD_WIDTH-1:0] sram_dout1;

    assign wb_cmd  = wbs_dat_i;
    assign wb_addr = wbs_adr_i - WB_ADDRESS_OFFSET;  // Low bits pick the word
    assign wb_req  = wb_mode_i & wbs_stb_i & wbs_cyc_i & ~pending_q;

    // One-hot lane enable, byte moved into its lane
    assign wb_mask  = MASK_WIDTH'(1) << wb_cmd.wr.lane;
    assign wb_wdata = WORD_WIDTH'(wb_cmd.wr.data) << {wb_cmd.wr.lane, 3'b000};

    // Port 0 owner follows the mode
    always_comb begin
        if (wb_mode_i) begin
            sram_csb0  = ~wb_req;
            sram_web0  = ~wbs_we_i;
            sram_addr0 = wb_addr[ADDR_WIDTH-1:0];
            sram_wmask = wb_mask;
            sram_din0  = wb_wdata;
        end else begin
            sram_csb0  = csb0_i;
            sram_web0  = web0_i;
            sram_addr0 = addr0_i;
            sram_wmask = '1;                      // Full patch, all lanes
            sram_din0  = WORD_WIDTH'(wpatch0_i);
        end
    end

    // Writes ack after one cycle, reads wait one more for the SRAM data
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= 1'b0;
            rd_wait_q <= 1'b0;
            ack_q     <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            if (wb_req) begin
                pending_q <= 1'b1;
                rd_wait_q <= ~wbs_we_i;
                ack_q     <= wbs_we_i;
            end else if (rd_wait_q) begin
                rd_wait_q <= 1'b0;
                ack_q     <= 1'b1;
            end else if (ack_q) begin
                pending_q <= 1'b0;  // Master drops stb this cycle
            end
        end
    end

    // Half select is taken from the request word
    always_ff @(posedge clk) begin
        if (wb_req) begin
            half_q <= wb_cmd.rd.half;
        end
    end

    assign wbs_ack_o = ack_q;
    assign wbs_dat_o = !ack_q ? 32'd0 :
                       half_q ? 32'(sram_dout0[PATCH_WIDTH-1:32]) : sram_dout0[31:0];

    assign rpatch0_o = sram_dout0[PATCH_WIDTH-1:0];
    assign rpatch1_o = sram_dout1[PATCH_WIDTH-1:0];

    sram_1kbyte_1rw1r sram_inst (
        .clk0_i  (clk),
        .csb0_i  (sram_csb0),
        .web0_i  (sram_web0),
        .wmask_i (sram_wmask),
        .addr0_i (sram_addr0),
        .din0_i  (sram_din0),
        .dout0_o (sram_dout0),
        .clk1_i  (clk),
        .csb1_i  (csb1_i),
        .addr1_i (addr1_i),
        .dout1_o (sram_dout1)
    );

endmodule

//--- hdl/patch_sad_unit.sv
`timescale 1ns/1ps

module patch_sad_unit
    import mem_cfg_pkg::*;
    import wb_bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n_i,

    // Candidate in
    input  logic                   cand_valid_i,
    input  logic [ADDR_WIDTH-1:0]  cand_addr_i,
    input  logic [PATCH_WIDTH-1:0] cand_patch_i,

    // Query fetch over SRAM port 1
    output logic                   csb1_o,
    output logic [ADDR_WIDTH-1:0]  addr1_o,
    input  logic [PATCH_WIDTH-1:0] rpatch1_i,

    // Score out
    output logic                   score_valid_o,
    output logic [SCORE_WIDTH-1:0] score_o
);

    logic                   s1_valid_q;
    logic [PATCH_WIDTH-1:0] s1_patch_q;
    logic [SCORE_WIDTH-1:0] sad_sum;

    function automatic logic [DATA_WIDTH-1:0] abs_diff(
        input logic [DATA_WIDTH-1:0] a,
        input logic [DATA_WIDTH-1:0] b
    );
        return (a > b) ? a - b : b - a;
    endfunction

    // Stage 1 sends the query read out with the candidate
    assign csb1_o  = ~cand_valid_i;
    assign addr1_o = cand_addr_i;

    always_ff @(posedge clk) begin
        s1_patch_q <= cand_patch_i;  // Lines up with the SRAM read data
    end

    // Stage 2 sums the absolute pixel differences
    always_comb begin
        sad_sum = '0;
        for (int i = 0; i < PATCH_SIZE; i++) begin
            sad_sum = sad_sum + SCORE_WIDTH'(abs_diff(rpatch1_i[i*DATA_WIDTH +: DATA_WIDTH],
                                                      s1_patch_q[i*DATA_WIDTH +: DATA_WIDTH]));
        end
    end

    always_ff @(posedge clk) begin
        score_o <= sad_sum;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_valid_q    <= 1'b0;
            score_valid_o <= 1'b0;
        end else begin
            s1_valid_q    <= cand_valid_i;
            score_valid_o <= s1_valid_q;
        end
    end

endmodule

//--- hdl/patch_match_top.sv
`timescale 1ns/1ps

module patch_match_top
    import mem_cfg_pkg::*;
    import wb_bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   wb_mode_i,

    // Direct store access
    input  logic                   csb0_i,
    input  logic                   web0_i,
    input  logic [ADDR_WIDTH-1:0]  addr0_i,
    input  logic [PATCH_WIDTH-1:0] wpatch0_i,
    output logic [PATCH_WIDTH-1:0] rpatch0_o,

    // Wishbone slave
    input  logic                   wbs_stb_i,
    input  logic                   wbs_cyc_i,
    input  logic                   wbs_we_i,
    input  logic [31:0]            wbs_dat_i,
    input  logic [31:0]            wbs_adr_i,
    output logic                   wbs_ack_o,
    output logic [31:0]            wbs_dat_o,

    // Scoring
    input  logic                   cand_valid_i,
    input  logic [ADDR_WIDTH-1:0]  cand_addr_i,
    input  logic [PATCH_WIDTH-1:0] cand_patch_i,
    output logic                   score_valid_o,
    output logic [SCORE_WIDTH-1:0] score_o
);

    // Port 1 between scorer and store
    logic                   csb1;
    logic [ADDR_WIDTH-1:0]  addr1;
    logic [PATCH_WIDTH-1:0] rpatch1;

    query_patch_mem query_patch_mem_inst (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .wb_mode_i (wb_mode_i),
        .csb0_i    (csb0_i),
        .web0_i    (web0_i),
        .addr0_i   (addr0_i),
        .wpatch0_i (wpatch0_i),
        .rpatch0_o (rpatch0_o),
        .csb1_i    (csb1),
        .addr1_i   (addr1),
        .rpatch1_o (rpatch1),
        .wbs_stb_i (wbs_stb_i),
        .wbs_cyc_i (wbs_cyc_i),
        .wbs_we_i  (wbs_we_i),
        .wbs_dat_i (wbs_dat_i),
        .wbs_adr_i (wbs_adr_i),
        .wbs_ack_o (wbs_ack_o),
        .wbs_dat_o (wbs_dat_o)
    );

    patch_sad_unit patch_sad_unit_inst (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .cand_valid_i  (cand_valid_i),
        .cand_addr_i   (cand_addr_i),
        .cand_patch_i  (cand_patch_i),
        .csb1_o        (csb1),
        .addr1_o       (addr1),
        .rpatch1_i     (rpatch1),
        .score_valid_o (score_valid_o),
        .score_o       (score_o)
    );

endmodule

//--- bench/patch_model.svh
`ifndef PATCH_MODEL_SVH
`define PATCH_MODEL_SVH

// Shadow copy of the SRAM contents
logic [WORD_WIDTH-1:0] shadow_mem [DEPTH];

// Byte-lane merge into a shadow word
function automatic void store_masked(input logic [ADDR_WIDTH-1:0] a,
                                     input logic [WORD_WIDTH-1:0] data,
                                     input logic [MASK_WIDTH-1:0] mask);
    for (int lane = 0; lane < MASK_WIDTH; lane++) begin
        if (mask[lane]) begin
            shadow_mem[a][lane*8 +: 8] = data[lane*8 +: 8];
        end
    end
endfunction

// Low half is patch bits 31..0, high half the remaining 23 bits
function automatic logic [31:0] read_half(input logic [ADDR_WIDTH-1:0] a, input logic half);
    return half ? 32'(shadow_mem[a][PATCH_WIDTH-1:32]) : shadow_mem[a][31:0];
endfunction

function automatic logic [SCORE_WIDTH-1:0] expected_sad(input logic [ADDR_WIDTH-1:0] a,
                                                        input logic [PATCH_WIDTH-1:0] cand);
    int total;
    int q;
    int c;
    total = 0;
    for (int i = 0; i < PATCH_SIZE; i++) begin
        q = int'(shadow_mem[a][i*DATA_WIDTH +: DATA_WIDTH]);
        c = int'(cand[i*DATA_WIDTH +: DATA_WIDTH]);
        total += (q > c) ? q - c : c - q;
    end
    return SCORE_WIDTH'(total);
endfunction

`endif

//--- bench/tb_patch_match.sv
`timescale 1ns/1ps

module tb_patch_match
    import mem_cfg_pkg::*;
    import wb_bus_pkg::*;
();

    localparam int N_FILL      = DEPTH;
    localparam int N_DIRECT    = 48;  // Write, read back, read elsewhere
    localparam int N_WB_WR     = 48;
    localparam int N_WB_RD     = 32;
    localparam int N_CAND      = 64;
    localparam int TOTAL_OPS   = N_FILL + 2 * N_DIRECT + 2 * N_WB_WR + N_WB_RD + N_CAND;
    localparam int WATCHDOG_NS = TOTAL_OPS * 10 * 8;

    logic                   clk = 1'b0;
    logic                   arst_n_i;
    logic                   wb_mode_i;
    logic                   csb0_i;
    logic                   web0_i;
    logic [ADDR_WIDTH-1:0]  addr0_i;
    logic [PATCH_WIDTH-1:0] wpatch0_i;
    logic [PATCH_WIDTH-1:0] rpatch0_o;
    logic                   wbs_stb_i;
    logic                   wbs_cyc_i;
    logic                   wbs_we_i;
    logic [31:0]            wbs_dat_i;
    logic [31:0]            wbs_adr_i;
    logic                   wbs_ack_o;
    logic [31:0]            wbs_dat_o;
    logic                   cand_valid_i;
    logic [ADDR_WIDTH-1:0]  cand_addr_i;
    logic [PATCH_WIDTH-1:0] cand_patch_i;
    logic                   score_valid_o;
    logic [SCORE_WIDTH-1:0] score_o;

    int                     error_count = 0;
    int                     check_count = 0;
    int                     cycle_cnt = 0;
    logic [SCORE_WIDTH-1:0] exp_scores [$];   // Scores still in flight in issue order
    int                     issue_cycles [$];

    `include "patch_model.svh"

    patch_match_top patch_match_top_inst (
        .clk (clk), .arst_n_i (arst_n_i), .wb_mode_i (wb_mode_i),
        .csb0_i (csb0_i), .web0_i (web0_i), .addr0_i (addr0_i),
        .wpatch0_i (wpatch0_i), .rpatch0_o (rpatch0_o),
        .wbs_stb_i (wbs_stb_i), .wbs_cyc_i (wbs_cyc_i), .wbs_we_i (wbs_we_i),
        .wbs_dat_i (wbs_dat_i), .wbs_adr_i (wbs_adr_i),
        .wbs_ack_o (wbs_ack_o), .wbs_dat_o (wbs_dat_o),
        .cand_valid_i (cand_valid_i), .cand_addr_i (cand_addr_i),
        .cand_patch_i (cand_patch_i), .score_valid_o (score_valid_o), .score_o (score_o)
    );

    always #4 clk = ~clk;  // 8 ns period

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic check_patch(input logic [PATCH_WIDTH-1:0] got, exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Mismatch at time %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_wb_word(input logic [31:0] got, exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Mismatch at time %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_score(input logic [SCORE_WIDTH-1:0] got, exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Mismatch at time %0t: %s got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    function automatic logic [PATCH_WIDTH-1:0] rand_patch();
        return PATCH_WIDTH'({$urandom(), $urandom()});
    endfunction

    task automatic direct_write(input logic [ADDR_WIDTH-1:0] addr,
                                input logic [PATCH_WIDTH-1:0] patch);
        csb0_i    = 1'b0;
        web0_i    = 1'b0;
        addr0_i   = addr;
        wpatch0_i = patch;
        @(negedge clk);
        csb0_i = 1'b1;
        web0_i = 1'b1;
        store_masked(addr, WORD_WIDTH'(patch), '1);  // Patch fills the low bits and the rest stays zero
    endtask

    // Data is registered, so it is sampled one cycle after the strobe
    task automatic verify_direct_read(input logic [ADDR_WIDTH-1:0] addr, input string what);
        csb0_i  = 1'b0;
        web0_i  = 1'b1;
        addr0_i = addr;
        @(negedge clk);
        csb0_i = 1'b1;
        check_patch(rpatch0_o, shadow_mem[addr][PATCH_WIDTH-1:0], what);
    endtask

    task automatic wb_access(input logic we, input logic [ADDR_WIDTH-1:0] word,
                             input wb_cmd_u cmd, input int exp_lat, output logic [31:0] rdata);
        int waited;
        waited    = 0;
        wbs_stb_i = 1'b1;
        wbs_cyc_i = 1'b1;
        wbs_we_i  = we;
        wbs_dat_i = cmd;
        // Random bits above the word index must not matter
        wbs_adr_i = WB_ADDRESS_OFFSET + {(32 - ADDR_WIDTH)'($urandom()), word};
        do begin
            @(negedge clk);
            waited++;
        end while (wbs_ack_o !== 1'b1 && waited < 10);
        if (wbs_ack_o !== 1'b1) begin
            error_count++;
            $display("No Wishbone acknowledge within 10 cycles at time %0t", $time);
        end else if (waited != exp_lat) begin
            error_count++;
            $display("Wishbone acknowledge after %0d cycles, expected %0d", waited, exp_lat);
        end
        rdata     = wbs_dat_o;
        wbs_stb_i = 1'b0;
        wbs_cyc_i = 1'b0;
        @(negedge clk);
        if (wbs_ack_o !== 1'b0) begin
            error_count++;
            $display("Wishbone acknowledge held longer than one cycle at time %0t", $time);
        end
    endtask

    always @(negedge clk) begin : score_monitor
        logic [SCORE_WIDTH-1:0] expected;
        int                     issued;
        if (arst_n_i === 1'b1 && score_valid_o === 1'b1) begin
            if (exp_scores.size() == 0) begin
                error_count++;
                $display("score_valid_o high at time %0t with no candidate in flight", $time);
            end else begin
                expected = exp_scores.pop_front();
                issued   = issue_cycles.pop_front();
                if (cycle_cnt - issued != 2) begin
                    error_count++;
                    $display("Score came %0d cycles after its candidate", cycle_cnt - issued);
                end
                check_score(score_o, expected, "SAD score");
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run stalled", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [ADDR_WIDTH-1:0]  addr;
        logic [PATCH_WIDTH-1:0] patch;
        logic [31:0]            rdata;
        wb_cmd_u                cmd;
        int                     lane;
        int                     waited;
        logic [ADDR_WIDTH-1:0]  wb_addrs [$];

        void'($urandom(32'h3898));
        arst_n_i     = 1'b0;
        wb_mode_i    = 1'b0;
        csb0_i       = 1'b1;
        web0_i       = 1'b1;
        addr0_i      = '0;
        wpatch0_i    = '0;
        wbs_stb_i    = 1'b0;
        wbs_cyc_i    = 1'b0;
        wbs_we_i     = 1'b0;
        wbs_dat_i    = '0;
        wbs_adr_i    = '0;
        cand_valid_i = 1'b0;
        cand_addr_i  = '0;
        cand_patch_i = '0;
        repeat (5) @(negedge clk);
        arst_n_i = 1'b1;
        @(negedge clk);
        if (wbs_ack_o !== 1'b0 || score_valid_o !== 1'b0) begin
            error_count++;
            $display("wbs_ack_o or score_valid_o not low after reset");
        end

        // Every word gets a known value first
        for (int a = 0; a < N_FILL; a++) direct_write(ADDR_WIDTH'(a), rand_patch());

        for (int i = 0; i < N_DIRECT; i++) begin
            addr = ADDR_WIDTH'($urandom());
            direct_write(addr, rand_patch());
            verify_direct_read(addr, "direct readback");
            verify_direct_read(ADDR_WIDTH'($urandom()), "direct read");
        end

        wb_mode_i = 1'b1;
        for (int i = 0; i < N_WB_WR; i++) begin
            addr = ADDR_WIDTH'($urandom());
            lane = int'($urandom() % MASK_WIDTH);
            cmd  = $urandom();                    // Reserved bits stay random
            cmd.wr.lane = 3'(lane);
            wb_access(1'b1, addr, cmd, 1, rdata);
            store_masked(addr, WORD_WIDTH'(cmd.wr.data) << (lane * 8), MASK_WIDTH'(1) << lane);
            wb_addrs.push_back(addr);
        end
        for (int i = 0; i < N_WB_RD; i++) begin
            addr = ADDR_WIDTH'($urandom());
            cmd  = $urandom();                    // Half select comes from the random word
            wb_access(1'b0, addr, cmd, 2, rdata);
            check_wb_word(rdata, read_half(addr, cmd.rd.half), "Wishbone half read");
        end
        wb_mode_i = 1'b0;
        foreach (wb_addrs[k]) verify_direct_read(wb_addrs[k], "byte-lane merge");

        // Back-to-back candidates with every eighth one an exact match
        for (int i = 0; i < N_CAND; i++) begin
            addr  = ADDR_WIDTH'($urandom());
            patch = (i % 8 == 0) ? shadow_mem[addr][PATCH_WIDTH-1:0] : rand_patch();
            cand_valid_i = 1'b1;
            cand_addr_i  = addr;
            cand_patch_i = patch;
            exp_scores.push_back(expected_sad(addr, patch));
            issue_cycles.push_back(cycle_cnt);
            @(negedge clk);
        end
        cand_valid_i = 1'b0;
        waited = 0;
        while (exp_scores.size() != 0 && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (exp_scores.size() != 0) begin
            error_count++;
            $display("%0d scores never arrived", exp_scores.size());
        end

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+bench
hdl/mem_cfg_pkg.sv
hdl/wb_bus_pkg.sv
hdl/sram_1kbyte_1rw1r.sv
hdl/query_patch_mem.sv
hdl/patch_sad_unit.sv
hdl/patch_match_top.sv
bench/tb_patch_match.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the patch-match testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -f all.f --top-module tb_patch_match \
    -Mdir "$BUILD_DIR" -o tb_patch_match
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_patch_match" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG_FILE"; then
    exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1
